/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = core_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FLIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  logic               fire_valid,
  input  ooo_pkg::word_t     fire_a,
  input  ooo_pkg::word_t     fire_b,
  input  isa_pkg::alu_func_e fire_func,
  input  ooo_pkg::rob_ix_t   fire_ix,
  output logic               accept,
  output logic               done_valid,
  output ooo_pkg::rob_ix_t   done_ix,
  output ooo_pkg::word_t     done_value,
  input  logic               grant
);
  ooo_pkg::word_t result;

  assign accept = !done_valid || grant; // free again on the grant edge

  always_comb begin
    case (fire_func)
      isa_pkg::ALU_SUB: result = fire_a - fire_b;
      isa_pkg::ALU_AND: result = fire_a & fire_b;
      isa_pkg::ALU_OR:  result = fire_a | fire_b;
      isa_pkg::ALU_XOR: result = fire_a ^ fire_b;
      isa_pkg::ALU_SLT: result = ooo_pkg::word_t'($signed(fire_a) < $signed(fire_b));
      isa_pkg::ALU_SLL: result = fire_a << fire_b[4:0];
      isa_pkg::ALU_SRL: result = fire_a >> fire_b[4:0];
      isa_pkg::ALU_PASSB: result = fire_b;
      default: result = fire_a + fire_b;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) done_valid <= 1'b0;
    else if (fire_valid && accept) done_valid <= 1'b1;
    else if (grant) done_valid <= 1'b0;
  end

  always_ff @(posedge clk_100mhz) begin
    if (fire_valid && accept) begin
      done_value <= result;
      done_ix <= fire_ix;
    end
  end

endmodule

/* design/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path width
`define XLEN 32

// reorder buffer, index width must cover the depth
`define ROB_DEPTH 8
`define ROB_IX_W 3

`define IQ_DEPTH 4   // instruction queue entries
`define MUL_STAGES 3 // multiplier pipe depth

`endif

/* design/isa_pkg.sv */
package isa_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_addr_t;

  // decoded class, anything unknown ends up as nop
  typedef enum logic [2:0] {
    ITYPE_NOP,
    ITYPE_OP,
    ITYPE_OPIMM,
    ITYPE_LUI,
    ITYPE_MUL
  } inst_type_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASSB // lui, operand b straight through
  } alu_func_e;

endpackage

/* design/issue_stage.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module issue_stage (
  input  logic                 clk_100mhz,
  input  logic                 sys_rst,
  input  isa_pkg::instr_t      instr,
  input  logic                 instr_valid,
  output logic                 instr_ready,
  output isa_pkg::reg_addr_t   rs1,
  output isa_pkg::reg_addr_t   rs2,
  input  ooo_pkg::rob_ix_t     rf_tag1,
  input  logic                 rf_tag1_valid,
  input  ooo_pkg::word_t       rf_value1,
  input  ooo_pkg::rob_ix_t     rf_tag2,
  input  logic                 rf_tag2_valid,
  input  ooo_pkg::word_t       rf_value2,
  output ooo_pkg::rob_ix_t     lookup1_ix,
  output ooo_pkg::rob_ix_t     lookup2_ix,
  input  ooo_pkg::word_t       lookup1_value,
  input  logic                 lookup1_done,
  input  ooo_pkg::word_t       lookup2_value,
  input  logic                 lookup2_done,
  input  logic                 rob_full,
  input  ooo_pkg::rob_ix_t     tail_ix,
  output logic                 issue_valid,
  output isa_pkg::reg_addr_t   issue_rd,
  input  logic                 alu_free,
  input  logic                 mul_free,
  output logic                 alu_issue,
  output logic                 mul_issue,
  output ooo_pkg::word_t       src1_value,
  output ooo_pkg::rob_ix_t     src1_tag,
  output logic                 src1_ready,
  output ooo_pkg::word_t       src2_value,
  output ooo_pkg::rob_ix_t     src2_tag,
  output logic                 src2_ready,
  output isa_pkg::alu_func_e   alu_func,
  output ooo_pkg::rob_ix_t     rob_ix
);
  localparam int PTR_W = $clog2(`IQ_DEPTH);

  isa_pkg::instr_t iq_mem [`IQ_DEPTH];
  logic [PTR_W-1:0] rd_ptr, wr_ptr;
  logic [PTR_W:0] count;
  logic push, pop, head_valid, can_issue, imm_op;
  isa_pkg::instr_t head;
  isa_pkg::inst_type_e itype;
  ooo_pkg::word_t imm;

  assign instr_ready = (count != `IQ_DEPTH);
  assign push = instr_valid && instr_ready;
  assign head_valid = (count != '0);
  assign head = iq_mem[rd_ptr];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (push) iq_mem[wr_ptr] <= instr;
  end

  // decode of the queue head
  always_comb begin
    itype = isa_pkg::ITYPE_NOP;
    alu_func = isa_pkg::ALU_ADD;
    imm = {{20{head[31]}}, head[31:20]}; // i-type
    case (head[6:0])
      7'b0110011: begin
        if (head[31:25] == 7'b0000001) begin
          if (head[14:12] == 3'b000) itype = isa_pkg::ITYPE_MUL; // mulh and div stay nop
        end else if (head[31:25] == 7'b0000000 || head[31:25] == 7'b0100000) begin
          itype = isa_pkg::ITYPE_OP;
          case ({head[30], head[14:12]})
            4'b0000: alu_func = isa_pkg::ALU_ADD;
            4'b1000: alu_func = isa_pkg::ALU_SUB;
            4'b0001: alu_func = isa_pkg::ALU_SLL;
            4'b0010: alu_func = isa_pkg::ALU_SLT;
            4'b0100: alu_func = isa_pkg::ALU_XOR;
            4'b0101: alu_func = isa_pkg::ALU_SRL;
            4'b0110: alu_func = isa_pkg::ALU_OR;
            4'b0111: alu_func = isa_pkg::ALU_AND;
            default: itype = isa_pkg::ITYPE_NOP; // sra, sltu
          endcase
        end
      end
      7'b0010011: begin
        itype = isa_pkg::ITYPE_OPIMM;
        case (head[14:12])
          3'b000: alu_func = isa_pkg::ALU_ADD;
          3'b010: alu_func = isa_pkg::ALU_SLT;
          3'b100: alu_func = isa_pkg::ALU_XOR;
          3'b110: alu_func = isa_pkg::ALU_OR;
          3'b111: alu_func = isa_pkg::ALU_AND;
          default: itype = isa_pkg::ITYPE_NOP; // shifts by immediate, sltiu
        endcase
      end
      7'b0110111: begin
        itype = isa_pkg::ITYPE_LUI;
        alu_func = isa_pkg::ALU_PASSB;
        imm = {head[31:12], 12'b0};
      end
      default: ;
    endcase
  end

  // lui reads x0 as operand one
  assign rs1 = (itype == isa_pkg::ITYPE_LUI) ? '0 : head[19:15];
  assign rs2 = head[24:20];
  assign lookup1_ix = rf_tag1;
  assign lookup2_ix = rf_tag2;
  assign src1_tag = rf_tag1;
  assign src2_tag = rf_tag2;
  assign imm_op = (itype == isa_pkg::ITYPE_OPIMM) || (itype == isa_pkg::ITYPE_LUI);

  // a renamed source takes the rob value once done and waits on the tag otherwise
  always_comb begin
    src1_value = rf_tag1_valid ? lookup1_value : rf_value1;
    src1_ready = !rf_tag1_valid || lookup1_done;
    if (imm_op) begin
      src2_value = imm;
      src2_ready = 1'b1;
    end else begin
      src2_value = rf_tag2_valid ? lookup2_value : rf_value2;
      src2_ready = !rf_tag2_valid || lookup2_done;
    end
  end

  assign can_issue = head_valid && !rob_full && (itype != isa_pkg::ITYPE_NOP);
  assign mul_issue = can_issue && (itype == isa_pkg::ITYPE_MUL) && mul_free;
  assign alu_issue = can_issue && (itype != isa_pkg::ITYPE_MUL) && alu_free;
  assign issue_valid = alu_issue || mul_issue;
  assign issue_rd = head[11:7];
  assign rob_ix = tail_ix;
  assign pop = issue_valid || (head_valid && itype == isa_pkg::ITYPE_NOP); // nop just drops

  // both stations never leave empty at the same edge
  one_station_per_issue: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst)
    (alu_free && mul_free) |=> (alu_free || mul_free));

endmodule

/* design/multiplier.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module multiplier (
  input  logic             clk_100mhz,
  input  logic             sys_rst,
  input  logic             fire_valid,
  input  ooo_pkg::word_t   fire_a,
  input  ooo_pkg::word_t   fire_b,
  input  ooo_pkg::rob_ix_t fire_ix,
  output logic             accept,
  output logic             done_valid,
  output ooo_pkg::rob_ix_t done_ix,
  output ooo_pkg::word_t   done_value,
  input  logic             grant
);
  localparam int N = `MUL_STAGES;

  logic [N-1:0] stage_valid;
  ooo_pkg::rob_ix_t stage_ix [N];
  ooo_pkg::word_t stage_prod [N];
  logic stall;

  assign stall = stage_valid[N-1] && !grant; // whole pipe freezes
  assign accept = !stall;
  assign done_valid = stage_valid[N-1];
  assign done_ix = stage_ix[N-1];
  assign done_value = stage_prod[N-1];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) stage_valid <= '0;
    else if (!stall) stage_valid <= {stage_valid[N-2:0], fire_valid};
  end

  always_ff @(posedge clk_100mhz) begin
    if (!stall) begin
      stage_prod[0] <= fire_a * fire_b; // low word only
      stage_ix[0] <= fire_ix;
      for (int i = 1; i < N; i++) begin
        stage_prod[i] <= stage_prod[i-1];
        stage_ix[i] <= stage_ix[i-1];
      end
    end
  end

  held_result_stable: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (done_valid && !grant) |=> (done_valid && $stable(done_value) && $stable(done_ix)));

endmodule

/* design/ooo_core_top.sv */
`timescale 1ns/1ps

module ooo_core_top (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  isa_pkg::instr_t    instr,
  input  logic               instr_valid,
  output logic               instr_ready,
  output logic               commit_valid,
  output isa_pkg::reg_addr_t commit_rd,
  output ooo_pkg::word_t     commit_value
);
  isa_pkg::reg_addr_t rs1, rs2, issue_rd;
  ooo_pkg::word_t rf_value1, rf_value2, lookup1_value, lookup2_value;
  ooo_pkg::rob_ix_t rf_tag1, rf_tag2, lookup1_ix, lookup2_ix, tail_ix, commit_ix;
  logic rf_tag1_valid, rf_tag2_valid, lookup1_done, lookup2_done;
  logic rob_full, issue_valid, alu_free, mul_free, alu_issue, mul_issue;

  // operands shared by both stations
  ooo_pkg::word_t src1_value, src2_value;
  ooo_pkg::rob_ix_t src1_tag, src2_tag, rob_ix;
  logic src1_ready, src2_ready;
  isa_pkg::alu_func_e alu_func;

  logic cdb_valid;
  ooo_pkg::rob_ix_t cdb_rob_ix;
  ooo_pkg::word_t cdb_value;

  logic alu_fire, alu_accept, alu_done_valid, alu_grant;
  ooo_pkg::word_t alu_a, alu_b, alu_done_value;
  ooo_pkg::rob_ix_t alu_fire_ix, alu_done_ix;
  isa_pkg::alu_func_e alu_fire_func;

  logic mul_fire, mul_accept, mul_done_valid, mul_grant;
  ooo_pkg::word_t mul_a, mul_b, mul_done_value;
  ooo_pkg::rob_ix_t mul_fire_ix, mul_done_ix;

  issue_stage issue0 (.*);

  register_file regs0 (.*);

  reorder_buffer rob0 (.*);

  reservation_station alu_station (
    .clk_100mhz, .sys_rst, .issue(alu_issue), .free(alu_free),
    .src1_value, .src1_tag, .src1_ready, .src2_value, .src2_tag, .src2_ready,
    .alu_func, .rob_ix, .cdb_valid, .cdb_rob_ix, .cdb_value,
    .fire_valid(alu_fire), .fire_a(alu_a), .fire_b(alu_b), .fire_func(alu_fire_func),
    .fire_ix(alu_fire_ix), .unit_accept(alu_accept)
  );

  reservation_station mul_station (
    .clk_100mhz, .sys_rst, .issue(mul_issue), .free(mul_free),
    .src1_value, .src1_tag, .src1_ready, .src2_value, .src2_tag, .src2_ready,
    .alu_func, .rob_ix, .cdb_valid, .cdb_rob_ix, .cdb_value,
    .fire_valid(mul_fire), .fire_a(mul_a), .fire_b(mul_b), .fire_func(),
    .fire_ix(mul_fire_ix), .unit_accept(mul_accept)
  );

  alu alu0 (
    .clk_100mhz, .sys_rst, .fire_valid(alu_fire), .fire_a(alu_a), .fire_b(alu_b),
    .fire_func(alu_fire_func), .fire_ix(alu_fire_ix), .accept(alu_accept),
    .done_valid(alu_done_valid), .done_ix(alu_done_ix), .done_value(alu_done_value),
    .grant(alu_grant)
  );

  multiplier mul0 (
    .clk_100mhz, .sys_rst, .fire_valid(mul_fire), .fire_a(mul_a), .fire_b(mul_b),
    .fire_ix(mul_fire_ix), .accept(mul_accept), .done_valid(mul_done_valid),
    .done_ix(mul_done_ix), .done_value(mul_done_value), .grant(mul_grant)
  );

endmodule

/* design/ooo_pkg.sv */
`include "core_defines.svh"

package ooo_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`ROB_IX_W-1:0] rob_ix_t;

  typedef enum logic [1:0] {
    RS_EMPTY,
    RS_WAIT, // at least one operand still tagged
    RS_FIRE
  } rs_state_e;

endpackage

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  isa_pkg::reg_addr_t rs1,
  input  isa_pkg::reg_addr_t rs2,
  output ooo_pkg::word_t     rf_value1,
  output ooo_pkg::word_t     rf_value2,
  output ooo_pkg::rob_ix_t   rf_tag1,
  output logic               rf_tag1_valid,
  output ooo_pkg::rob_ix_t   rf_tag2,
  output logic               rf_tag2_valid,
  input  logic               issue_valid,
  input  isa_pkg::reg_addr_t issue_rd,
  input  ooo_pkg::rob_ix_t   tail_ix,
  input  logic               commit_valid,
  input  isa_pkg::reg_addr_t commit_rd,
  input  ooo_pkg::word_t     commit_value,
  input  ooo_pkg::rob_ix_t   commit_ix
);
  ooo_pkg::word_t regs [32];
  ooo_pkg::rob_ix_t tags [32];
  logic [31:0] tag_valid;

  assign rf_value1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rf_value2 = (rs2 == '0) ? '0 : regs[rs2];
  assign rf_tag1 = tags[rs1];
  assign rf_tag2 = tags[rs2];
  assign rf_tag1_valid = tag_valid[rs1]; // x0 is never renamed
  assign rf_tag2_valid = tag_valid[rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      tag_valid <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit_valid && commit_rd != '0) begin
        regs[commit_rd] <= commit_value;
        // a younger writer keeps its tag
        if (tags[commit_rd] == commit_ix) tag_valid[commit_rd] <= 1'b0;
      end
      if (issue_valid && issue_rd != '0) begin // rename last, so it wins
        tags[issue_rd] <= tail_ix;
        tag_valid[issue_rd] <= 1'b1;
      end
    end
  end

endmodule

/* design/reorder_buffer.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module reorder_buffer (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  logic               issue_valid,
  input  isa_pkg::reg_addr_t issue_rd,
  output ooo_pkg::rob_ix_t   tail_ix,
  output logic               rob_full,
  input  ooo_pkg::rob_ix_t   lookup1_ix,
  input  ooo_pkg::rob_ix_t   lookup2_ix,
  output ooo_pkg::word_t     lookup1_value,
  output logic               lookup1_done,
  output ooo_pkg::word_t     lookup2_value,
  output logic               lookup2_done,
  input  logic               alu_done_valid,
  input  ooo_pkg::rob_ix_t   alu_done_ix,
  input  ooo_pkg::word_t     alu_done_value,
  output logic               alu_grant,
  input  logic               mul_done_valid,
  input  ooo_pkg::rob_ix_t   mul_done_ix,
  input  ooo_pkg::word_t     mul_done_value,
  output logic               mul_grant,
  output logic               cdb_valid,
  output ooo_pkg::rob_ix_t   cdb_rob_ix,
  output ooo_pkg::word_t     cdb_value,
  output logic               commit_valid,
  output isa_pkg::reg_addr_t commit_rd,
  output ooo_pkg::word_t     commit_value,
  output ooo_pkg::rob_ix_t   commit_ix
);
  ooo_pkg::word_t value [`ROB_DEPTH];
  isa_pkg::reg_addr_t dest [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] valid, done;
  ooo_pkg::rob_ix_t head, tail, win_ix;
  ooo_pkg::word_t win_value;
  logic [`ROB_IX_W:0] count;
  logic retire, any_done;

  assign tail_ix = tail;
  assign rob_full = (count == `ROB_DEPTH);
  assign retire = valid[head] && done[head];

  assign lookup1_value = value[lookup1_ix];
  assign lookup1_done = done[lookup1_ix];
  assign lookup2_value = value[lookup2_ix];
  assign lookup2_done = done[lookup2_ix];

  // fixed priority, alu first
  assign alu_grant = alu_done_valid;
  assign mul_grant = mul_done_valid && !alu_done_valid;
  assign any_done = alu_done_valid || mul_done_valid;
  assign win_ix = alu_done_valid ? alu_done_ix : mul_done_ix;
  assign win_value = alu_done_valid ? alu_done_value : mul_done_value;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      valid <= '0;
      done <= '0;
      cdb_valid <= 1'b0;
      commit_valid <= 1'b0;
    end else begin
      if (issue_valid) begin
        valid[tail] <= 1'b1;
        done[tail] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (any_done) done[win_ix] <= 1'b1; // same edge the bus loads
      if (retire) begin
        valid[head] <= 1'b0; // done and value stay readable until reuse
        head <= head + 1'b1;
      end
      cdb_valid <= any_done;
      commit_valid <= retire;
      count <= count + {{`ROB_IX_W{1'b0}}, issue_valid} - {{`ROB_IX_W{1'b0}}, retire};
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (issue_valid) dest[tail] <= issue_rd;
    if (any_done) value[win_ix] <= win_value;
    cdb_rob_ix <= win_ix;
    cdb_value <= win_value;
    commit_rd <= dest[head];
    commit_value <= value[head];
    commit_ix <= head;
  end

  cdb_tag_in_flight: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst) cdb_valid |-> valid[cdb_rob_ix]);

endmodule

/* design/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  logic               issue,
  output logic               free,
  input  ooo_pkg::word_t     src1_value,
  input  ooo_pkg::rob_ix_t   src1_tag,
  input  logic               src1_ready,
  input  ooo_pkg::word_t     src2_value,
  input  ooo_pkg::rob_ix_t   src2_tag,
  input  logic               src2_ready,
  input  isa_pkg::alu_func_e alu_func,
  input  ooo_pkg::rob_ix_t   rob_ix,
  input  logic               cdb_valid,
  input  ooo_pkg::rob_ix_t   cdb_rob_ix,
  input  ooo_pkg::word_t     cdb_value,
  output logic               fire_valid,
  output ooo_pkg::word_t     fire_a,
  output ooo_pkg::word_t     fire_b,
  output isa_pkg::alu_func_e fire_func,
  output ooo_pkg::rob_ix_t   fire_ix,
  input  logic               unit_accept
);
  ooo_pkg::rs_state_e state;
  ooo_pkg::rob_ix_t a_tag, b_tag;
  logic a_rdy, b_rdy, a_hit, b_hit;

  assign free = (state == ooo_pkg::RS_EMPTY);
  assign fire_valid = (state == ooo_pkg::RS_FIRE);
  // snoop the bus for a missing operand
  assign a_hit = (state == ooo_pkg::RS_WAIT) && cdb_valid && !a_rdy && (cdb_rob_ix == a_tag);
  assign b_hit = (state == ooo_pkg::RS_WAIT) && cdb_valid && !b_rdy && (cdb_rob_ix == b_tag);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= ooo_pkg::RS_EMPTY;
      a_rdy <= 1'b0;
      b_rdy <= 1'b0;
    end else begin
      case (state)
        ooo_pkg::RS_EMPTY: if (issue) begin
          a_rdy <= src1_ready;
          b_rdy <= src2_ready;
          state <= (src1_ready && src2_ready) ? ooo_pkg::RS_FIRE : ooo_pkg::RS_WAIT;
        end
        ooo_pkg::RS_WAIT: begin
          if (a_hit) a_rdy <= 1'b1;
          if (b_hit) b_rdy <= 1'b1;
          if ((a_rdy || a_hit) && (b_rdy || b_hit)) state <= ooo_pkg::RS_FIRE;
        end
        ooo_pkg::RS_FIRE: if (unit_accept) state <= ooo_pkg::RS_EMPTY;
        default: state <= ooo_pkg::RS_EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (issue && free) begin
      fire_a <= src1_value;
      fire_b <= src2_value;
      a_tag <= src1_tag;
      b_tag <= src2_tag;
      fire_func <= alu_func;
      fire_ix <= rob_ix;
    end else begin
      if (a_hit) fire_a <= cdb_value;
      if (b_hit) fire_b <= cdb_value;
    end
  end

endmodule

/* flist.f */
+incdir+design
design/isa_pkg.sv
design/ooo_pkg.sv
design/issue_stage.sv
design/register_file.sv
design/reorder_buffer.sv
design/reservation_station.sv
design/alu.sv
design/multiplier.sv
design/ooo_core_top.sv
verification/tb_clock.sv
verification/core_tb.sv

/* verification/core_tb.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_tb;
  // 14 independent + 6 chain + 6 mul + 4 x0 + 40 random
  localparam int N_WORDS = 70;
  localparam int LIMIT = N_WORDS * (`ROB_DEPTH + `MUL_STAGES + 4) + 100;

  logic clk_100mhz, sys_rst, instr_valid, instr_ready, commit_valid;
  isa_pkg::instr_t instr;
  isa_pkg::reg_addr_t commit_rd, want_rd;
  ooo_pkg::word_t commit_value, want_value;

  isa_pkg::instr_t accepted [$];
  ooo_pkg::word_t model_regs [32];
  isa_pkg::reg_addr_t exp_rd [N_WORDS];
  ooo_pkg::word_t exp_value [N_WORDS];
  int push_ptr = 0;
  int commit_ptr = 0;
  int n_sent = 0;
  int errors = 0;
  int cycles = 0;
  int ready_low_cycles = 0;
  int low_before;
  logic [15:0] lfsr;

  tb_clock clock0 (.clk_100mhz, .sys_rst);

  ooo_core_top dut0 (.*);

  assign want_rd = exp_rd[commit_ptr];
  assign want_value = exp_value[commit_ptr];

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1); // galois, taps 16 14 13 11
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic isa_pkg::instr_t op_word(input logic [6:0] f7, input logic [2:0] f3,
      input isa_pkg::reg_addr_t rd, input isa_pkg::reg_addr_t rs1,
      input isa_pkg::reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic isa_pkg::instr_t imm_word(input logic [2:0] f3,
      input isa_pkg::reg_addr_t rd, input isa_pkg::reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic isa_pkg::instr_t lui_word(input isa_pkg::reg_addr_t rd,
      input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  // only small registers, so random ops depend on each other a lot
  function automatic isa_pkg::instr_t random_instr();
    logic [2:0] kind, f3;
    isa_pkg::reg_addr_t rd, rs1, rs2;
    kind = 3'(rand_bits(3));
    f3 = 3'(rand_bits(3));
    rd = {2'b00, 3'(rand_bits(3))};
    rs1 = {2'b00, 3'(rand_bits(3))};
    rs2 = {2'b00, 3'(rand_bits(3))};
    case (kind)
      3'd0, 3'd1: begin
        if (f3 == 3'd3) f3 = 3'd0; // no sltu
        return op_word((f3 == 3'd0 && rand_bits(1) == 1) ? 7'h20 : 7'h00, f3, rd, rs1, rs2);
      end
      3'd2, 3'd3, 3'd6: begin
        if (f3[0] && f3 != 3'd7) f3 = 3'd0; // shifts and sltiu unsupported
        return imm_word(f3, rd, rs1, 12'(rand_bits(12)));
      end
      3'd4: return lui_word(rd, 20'(rand_bits(20)));
      default: return op_word(7'h01, 3'b000, rd, rs1, rs2);
    endcase
  endfunction

  // rv32 semantics on the model registers
  function automatic ooo_pkg::word_t model_result(input isa_pkg::instr_t w);
    ooo_pkg::word_t a, b;
    logic [3:0] sel;
    a = model_regs[w[19:15]];
    b = model_regs[w[24:20]];
    sel = {w[30], w[14:12]};
    if (w[6:0] == 7'b0110111) return {w[31:12], 12'h000};
    if (w[6:0] == 7'b0010011) begin
      b = {{20{w[31]}}, w[31:20]};
      sel[3] = 1'b0; // bit 30 is immediate here
    end else if (w[25]) begin
      return a * b;
    end
    case (sel)
      4'b0000: return a + b;
      4'b1000: return a - b;
      4'b0001: return a << b[4:0];
      4'b0010: return ooo_pkg::word_t'($signed(a) < $signed(b));
      4'b0100: return a ^ b;
      4'b0101: return a >> b[4:0];
      4'b0110: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic send(input isa_pkg::instr_t word);
    logic taken;
    taken = 1'b0;
    instr = word;
    instr_valid = 1'b1;
    while (!taken) begin
      taken = instr_ready; // stable between edges
      @(posedge clk_100mhz);
      #1;
    end
    instr_valid = 1'b0;
    n_sent++;
  endtask

  task automatic drain();
    while (commit_ptr < n_sent) begin
      @(posedge clk_100mhz);
      #1;
    end
  endtask

  // record accepted words and run them through the model in order
  always @(posedge clk_100mhz) begin
    if (!sys_rst && instr_valid && instr_ready) begin
      accepted.push_back(instr);
      exp_rd[push_ptr] = instr[11:7];
      exp_value[push_ptr] = model_result(instr);
      if (instr[11:7] != 5'd0) model_regs[instr[11:7]] = exp_value[push_ptr];
      push_ptr++;
    end
    if (!sys_rst && !instr_ready) ready_low_cycles++;
    if (!sys_rst && commit_valid) commit_ptr <= commit_ptr + 1;
  end

  always @(posedge clk_100mhz) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("timeout after %0d cycles, %0d of %0d words committed", cycles, commit_ptr,
               n_sent);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  reset_commit_quiet: assert property (@(posedge clk_100mhz) $past(sys_rst) |-> !commit_valid)
    else begin
      errors++;
      $display("FAILED t=%0t commit_valid got %0b expected 0", $time, $sampled(commit_valid));
    end

  reset_ready_high: assert property (@(posedge clk_100mhz) $past(sys_rst) |-> instr_ready)
    else begin
      errors++;
      $display("FAILED t=%0t instr_ready got %0b expected 1", $time, $sampled(instr_ready));
    end

  commit_expected: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    commit_valid |-> commit_ptr < push_ptr)
    else begin
      errors++;
      $display("commit at t=%0t has no matching accepted instruction", $time);
    end

  commit_rd_match: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    commit_valid |-> commit_rd == want_rd)
    else begin
      errors++;
      $display("FAILED t=%0t commit_rd got %0d expected %0d", $time, $sampled(commit_rd),
               $sampled(want_rd));
    end

  commit_value_match: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    commit_valid |-> commit_value == want_value)
    else begin
      errors++;
      $display("FAILED t=%0t commit_value got %h expected %h", $time, $sampled(commit_value),
               $sampled(want_value));
    end

  initial begin
    instr = '0;
    instr_valid = 1'b0;
    lfsr = 16'd81;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    @(posedge clk_100mhz);
    while (sys_rst) @(posedge clk_100mhz);
    #1;

    // independent op-imm and lui, then ops on committed values
    send(imm_word(3'b000, 5'd1, 5'd0, 12'd100));
    send(imm_word(3'b000, 5'd2, 5'd0, 12'hFF9)); // -7
    send(lui_word(5'd3, 20'h12345));
    send(imm_word(3'b110, 5'd4, 5'd0, 12'h0F0));
    send(imm_word(3'b100, 5'd5, 5'd0, 12'h555));
    send(imm_word(3'b010, 5'd6, 5'd0, 12'd5));
    drain();
    send(op_word(7'h00, 3'b000, 5'd7, 5'd1, 5'd2));
    send(op_word(7'h20, 3'b000, 5'd8, 5'd1, 5'd2));
    send(op_word(7'h00, 3'b111, 5'd9, 5'd3, 5'd4));
    send(op_word(7'h00, 3'b110, 5'd10, 5'd3, 5'd5));
    send(op_word(7'h00, 3'b100, 5'd11, 5'd4, 5'd5));
    send(op_word(7'h00, 3'b010, 5'd12, 5'd2, 5'd1));
    send(op_word(7'h00, 3'b001, 5'd13, 5'd1, 5'd5));
    send(op_word(7'h00, 3'b101, 5'd25, 5'd3, 5'd4));
    drain();

    // each one reads the previous result while in flight
    send(imm_word(3'b000, 5'd14, 5'd1, 12'd3));
    send(op_word(7'h00, 3'b000, 5'd14, 5'd14, 5'd14));
    send(op_word(7'h01, 3'b000, 5'd15, 5'd14, 5'd14));
    send(op_word(7'h20, 3'b000, 5'd15, 5'd15, 5'd14));
    send(op_word(7'h00, 3'b100, 5'd16, 5'd15, 5'd14));
    send(op_word(7'h00, 3'b000, 5'd16, 5'd16, 5'd15));
    drain();

    // muls first, the alu ops behind them finish earlier
    send(op_word(7'h01, 3'b000, 5'd17, 5'd1, 5'd2));
    send(op_word(7'h01, 3'b000, 5'd18, 5'd3, 5'd4));
    send(op_word(7'h01, 3'b000, 5'd19, 5'd5, 5'd7));
    send(op_word(7'h00, 3'b000, 5'd20, 5'd1, 5'd8));
    send(imm_word(3'b110, 5'd21, 5'd9, 12'h123));
    send(lui_word(5'd22, 20'hABCDE));
    drain();

    // x0 writes commit but never stick
    send(imm_word(3'b000, 5'd0, 5'd0, 12'd123));
    send(op_word(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
    send(op_word(7'h00, 3'b000, 5'd23, 5'd0, 5'd1));
    send(imm_word(3'b000, 5'd24, 5'd0, 12'd9));
    drain();

    low_before = ready_low_cycles;
    for (int i = 0; i < 40; i++) send(random_instr());
    drain();
    repeat (`ROB_DEPTH) @(posedge clk_100mhz);
    #1;
    assert (ready_low_cycles > low_before) else begin
      errors++;
      $display("instr_ready never went low during the random burst");
    end
    assert (commit_ptr == accepted.size()) else begin
      errors++;
      $display("%0d commits seen for %0d accepted words", commit_ptr, accepted.size());
    end

    $display("accepted %0d, committed %0d, errors %0d", accepted.size(), commit_ptr, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk_100mhz,
  output logic sys_rst
);
  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz; // 10 ns period
  end

  // reset held over the first 16 rising edges
  initial begin
    sys_rst = 1'b1;
    repeat (16) @(posedge clk_100mhz);
    sys_rst <= 1'b0;
  end
endmodule
